/* build.f */
+incdir+design
design/ro_pkg.sv
design/ro_mshr_if.sv
design/ro_free_list.sv
design/ro_burst_splitter.sv
design/ro_resp_unpacker.sv
design/read_only_stage.sv
tb/ro_mem_model.sv
tb/read_only_stage_assert.sv
tb/tb_read_only_stage.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
TOP       = tb_read_only_stage
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only if the log holds the pass line
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/ro_tests.txt */
# name group tag(hex) addr(hex) words first_data(hex) last_data(hex)
# requests that share a group are in flight together
single_word 1 01 00001000 1  a5a51000 a5a51000
short_mid   2 02 00001024 5  a5a51024 a5a51034
full_line   3 03 00002000 16 a5a52000 a5a5203c
cross_two   4 10 00003038 6  a5a53038 a5a5304c
max_words   5 11 00004004 64 a5a54004 a5a54100
cross_three 6 12 0000503c 18 a5a5503c a5a55080
mix_a       7 20 00006010 20 a5a56010 a5a5605c
mix_b       7 21 00007000 33 a5a57000 a5a57080
mix_c       7 22 00008ff8 9  a5a58ff8 a5a59018
mix_d       7 23 0000a03c 2  a5a5a03c a5a5a040
bp_a        8 30 0000b000 64 a5a5b000 a5a5b0fc
bp_b        8 31 0000c100 40 a5a5c100 a5a5c19c
bp_c        8 32 0000d07c 1  a5a5d07c a5a5d07c
lim_0       9 40 0000e000 4  a5a5e000 a5a5e00c
lim_1       9 41 0000e100 4  a5a5e100 a5a5e10c
lim_2       9 42 0000e200 4  a5a5e200 a5a5e20c
lim_3       9 43 0000e300 4  a5a5e300 a5a5e30c
lim_4       9 44 0000e400 4  a5a5e400 a5a5e40c

/* tb/tb_read_only_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ro_macros.svh"

module tb_read_only_stage import ro_pkg::*; ();

   localparam int MAX_TESTS = 32;

   logic      clk = 1'b0;
   logic      rstn, hold, idle;
   logic      req_valid, req_ready, arvalid, arready, rvalid, rready;
   logic      out_valid, out_ready, out_last;
   addr_t     req_addr, araddr;
   word_cnt_t req_n_words, out_word_id;
   tag_t      req_tag, out_tag;
   arid_t     arid, rid;
   line_t     rdata;
   word_t     out_data;

   string       t_name  [MAX_TESTS];
   int          t_group [MAX_TESTS];
   tag_t        t_tag   [MAX_TESTS];
   addr_t       t_addr  [MAX_TESTS];
   int          t_n     [MAX_TESTS];
   word_t       t_first [MAX_TESTS];
   word_t       t_last  [MAX_TESTS];
   logic [63:0] seen    [MAX_TESTS];   // word indices delivered so far
   int          got     [MAX_TESTS];
   int          lasts   [MAX_TESTS];
   int          beats   [MAX_TESTS];
   int          errs    [MAX_TESTS];
   bit          done    [MAX_TESTS];
   int          tag_test [256];
   bit          arid_out [2 ** `RO_LOG_N_ARID];   // read ids with a line outstanding
   int          ar_order [$];          // accepted requests still owed beats
   int          n_tests = 0;
   int          errors = 0;
   int          n_pass = 0;
   int          n_fail = 0;
   int          total_words = 0;

   read_only_stage DUT (.*);
   ro_mem_model mem (.*);

   always #5 clk = ~clk;

   always @(posedge clk) out_ready <= rstn && ($urandom_range(0, 3) != 0);

   function automatic word_t mem_word(input addr_t a);
      return a ^ 32'hA5A50000;
   endfunction

   function automatic int line_count(input int k);
      return int'(((t_addr[k] + 32'(4 * t_n[k]) - 1) >> 6) - (t_addr[k] >> 6)) + 1;
   endfunction

   task automatic finish_test(input int k);
      assert (lasts[k] == 1) else begin
         $display("[FAIL] %s: out_last count expected 1, actual %0d", t_name[k], lasts[k]);
         errs[k]++;
      end
      assert (beats[k] == line_count(k)) else begin
         $display("[FAIL] %s: address beats expected %0d, actual %0d",
                  t_name[k], line_count(k), beats[k]);
         errs[k]++;
      end
      if (errs[k] == 0) begin
         n_pass++;
         $display("test %s ok, %0d words in %0d beats", t_name[k], t_n[k], beats[k]);
      end else begin
         n_fail++;
         $display("test %s failed with %0d errors", t_name[k], errs[k]);
      end
      done[k] = 1'b1;
   endtask

   // a read id is reused only after its line came back
   task automatic check_arid(input arid_t id);
      assert (!arid_out[id]) else begin
         $display("read id %0d issued again while its line was still outstanding", id);
         errors++;
      end
      arid_out[id] = 1'b1;
   endtask

   task automatic check_beat(input addr_t a);
      int    k;
      addr_t exp;
      assert (ar_order.size() > 0) else begin
         $display("read-address beat at %h with no request expecting one", a);
         errors++;
      end
      if (ar_order.size() > 0) begin
         k = ar_order[0];
         // first beat keeps the request address, later ones start a line
         exp = (beats[k] == 0) ? t_addr[k] : ((t_addr[k] >> 6) + addr_t'(beats[k])) << 6;
         assert (a == exp) else begin
            $display("[FAIL] %s: beat %0d address expected %h, actual %h",
                     t_name[k], beats[k], exp, a);
            errs[k]++;
         end
         beats[k]++;
         if (beats[k] == line_count(k)) void'(ar_order.pop_front());
      end
   endtask

   task automatic check_word(input tag_t tag, input int idx, input word_t data, input logic last);
      int    k;
      word_t exp;
      bit    exp_last;
      k = tag_test[tag];
      assert (k >= 0) else begin
         $display("output word carries tag %h, which no request used", tag);
         errors++;
      end
      if (k >= 0) begin
         exp      = mem_word(t_addr[k] + 32'(4 * idx));
         exp_last = (got[k] + 1 == t_n[k]);
         assert (idx < t_n[k]) else begin
            $display("[FAIL] %s: word index expected below %0d, actual %0d", t_name[k], t_n[k], idx);
            errs[k]++;
         end
         assert (idx >= t_n[k] || !seen[k][idx]) else begin
            $display("%s: word index %0d was delivered twice", t_name[k], idx);
            errs[k]++;
         end
         assert (data == exp) else begin
            $display("[FAIL] %s: word %0d data expected %h, actual %h", t_name[k], idx, exp, data);
            errs[k]++;
         end
         assert (idx != 0 || data == t_first[k]) else begin
            $display("[FAIL] %s: first data expected %h, actual %h", t_name[k], t_first[k], data);
            errs[k]++;
         end
         assert (idx != t_n[k] - 1 || data == t_last[k]) else begin
            $display("[FAIL] %s: last data expected %h, actual %h", t_name[k], t_last[k], data);
            errs[k]++;
         end
         assert (last == exp_last) else begin
            $display("[FAIL] %s: out_last on word %0d expected %0b, actual %0b",
                     t_name[k], idx, exp_last, last);
            errs[k]++;
         end
         if (idx < t_n[k]) seen[k][idx] = 1'b1;
         if (last) lasts[k]++;
         got[k]++;
         total_words++;
         if (got[k] == t_n[k]) finish_test(k);
      end
   endtask

   // beats belong to requests in the order they were accepted
   always @(posedge clk) begin
      if (rstn && req_valid && req_ready) ar_order.push_back(tag_test[req_tag]);
      if (rstn && rvalid && rready) arid_out[rid] = 1'b0;
      if (rstn && arvalid && arready) begin
         check_arid(arid);
         check_beat(araddr);
      end
      if (rstn && out_valid && out_ready) begin
         check_word(out_tag, int'(out_word_id), out_data, out_last);
      end
   end

   task automatic load_tests();
      int    fd;
      int    k;
      string line;
      fd = $fopen("tb/ro_tests.txt", "r");
      if (fd != 0) begin
         while (!$feof(fd) && n_tests < MAX_TESTS) begin
            line = "";
            void'($fgets(line, fd));
            k = n_tests;
            if (line.len() > 1 && line.getc(0) != "#" &&
                $sscanf(line, "%s %d %h %h %d %h %h", t_name[k], t_group[k], t_tag[k],
                        t_addr[k], t_n[k], t_first[k], t_last[k]) == 7) begin
               tag_test[t_tag[k]] = k;
               seen[k]  = '0;
               got[k]   = 0;
               lasts[k] = 0;
               beats[k] = 0;
               errs[k]  = 0;
               done[k]  = 1'b0;
               n_tests++;
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic drive_request(input int k);
      @(posedge clk);
      req_valid   <= 1'b1;
      req_addr    <= t_addr[k];
      req_n_words <= word_cnt_t'(t_n[k]);
      req_tag     <= t_tag[k];
   endtask

   task automatic wait_accept();
      while (!req_ready) @(posedge clk);
      req_valid <= 1'b0;
   endtask

   // every thread busy and no response released, so this one has to wait
   task automatic issue_over_limit(input int k);
      drive_request(k);
      repeat (20) begin
         @(posedge clk);
         assert (!req_ready) else begin
            $display("%s: request accepted while every thread was busy", t_name[k]);
            errs[k]++;
         end
         assert (!idle) else begin
            $display("%s: idle high while requests were in flight", t_name[k]);
            errs[k]++;
         end
      end
      hold <= 1'b0;
      wait_accept();
   endtask

   task automatic run_group(input int first, input int cnt);
      int w;
      bit limit;
      limit = (cnt > `RO_N_THREADS);
      hold <= limit;
      for (int i = 0; i < cnt; i++) begin
         if (limit && i == `RO_N_THREADS) begin
            issue_over_limit(first + i);
         end else begin
            drive_request(first + i);
            @(posedge clk);
            wait_accept();
         end
      end
      for (int i = 0; i < cnt; i++) begin
         while (!done[first + i]) @(posedge clk);
      end
      w = 0;
      while (!idle && w < 4) begin
         @(posedge clk);
         w++;
      end
      assert (idle) else begin
         $display("idle stayed low after group %0d finished", t_group[first]);
         errors++;
      end
   endtask

   initial begin
      int k;
      int cnt;
      int sum;
      rstn        = 1'b0;
      hold        = 1'b0;
      req_valid   = 1'b0;
      req_addr    = '0;
      req_n_words = '0;
      req_tag     = '0;
      out_ready   = 1'b0;
      void'($urandom(32'hb324));
      for (int t = 0; t < 256; t++) tag_test[t] = -1;
      load_tests();
      if (n_tests == 0) begin
         $display("no tests could be read from tb/ro_tests.txt");
         $display("Testbench failed");
         $finish;
      end else begin
         repeat (3) @(posedge clk);
         rstn <= 1'b1;
         k = 0;
         sum = 0;
         while (k < n_tests) begin
            cnt = 1;
            while (k + cnt < n_tests && t_group[k + cnt] == t_group[k]) cnt++;
            run_group(k, cnt);
            k += cnt;
         end
         for (int t = 0; t < n_tests; t++) sum += t_n[t];
         repeat (5) @(posedge clk);
         assert (total_words == sum) else begin
            $display("[FAIL] word total: expected %0d, actual %0d", sum, total_words);
            errors++;
         end
         $display("tests %0d, ok %0d, with errors %0d, other errors %0d, words %0d",
                  n_tests, n_pass, n_fail, errors, total_words);
         if (errors == 0 && n_fail == 0 && n_pass == n_tests) begin
            $display("Testbench passed");
         end else begin
            $display("Testbench failed");
         end
         $finish;
      end
   end

   // 200 cycles per test plus the reset
   initial begin
      wait (n_tests > 0);
      repeat (200 * n_tests + 10) @(posedge clk);
      $display("timeout: tests did not finish within %0d cycles", 200 * n_tests + 10);
      $display("Testbench failed");
      $finish;
   end

endmodule

`default_nettype wire

/* tb/read_only_stage_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module read_only_stage_assert import ro_pkg::*; (
   input wire        clk,
   input wire        rstn,
   input wire        arvalid,
   input wire        arready,
   input wire addr_t araddr,
   input wire        out_valid,
   input wire        out_ready,
   input wire word_t out_data
);

   // a beat that is not taken stays put
   ar_held: assert property (@(posedge clk) disable iff (!rstn)
      arvalid && !arready |=> arvalid && $stable(araddr))
      else $error("read-address beat changed or dropped before arready");

   out_held: assert property (@(posedge clk) disable iff (!rstn)
      out_valid && !out_ready |=> out_valid && $stable(out_data))
      else $error("output word changed or dropped before out_ready");

   reset_quiet: assert property (@(posedge clk) $rose(rstn) |-> !arvalid && !out_valid)
      else $error("valid high in the first cycle after reset");

endmodule

bind read_only_stage read_only_stage_assert assert_u (
   .clk       (clk),
   .rstn      (rstn),
   .arvalid   (arvalid),
   .arready   (arready),
   .araddr    (araddr),
   .out_valid (out_valid),
   .out_ready (out_ready),
   .out_data  (out_data)
);

`default_nettype wire

/* tb/ro_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ro_macros.svh"

module ro_mem_model import ro_pkg::*; (
   input  wire         clk,
   input  wire         rstn,
   input  wire         hold,      // keep responses back
   input  wire         arvalid,
   output logic        arready,
   input  wire addr_t  araddr,
   input  wire arid_t  arid,
   output logic        rvalid,
   input  wire         rready,
   output arid_t       rid,
   output line_t       rdata
);

   addr_t pend_addr [$];
   arid_t pend_id   [$];

   // word at byte address a holds a ^ 32'hA5A50000
   function automatic line_t fill_line(input addr_t a);
      line_t l;
      addr_t base;
      base = {a[31:6], 6'b0};
      for (int k = 0; k < `RO_LINE_WORDS; k++) begin
         l[k * `RO_WORD_BITS +: `RO_WORD_BITS] = (base + addr_t'(4 * k)) ^ 32'hA5A50000;
      end
      return l;
   endfunction

   initial begin
      arready = 1'b0;
      rvalid  = 1'b0;
      rid     = '0;
      rdata   = '0;
   end

   always @(posedge clk) begin
      int pick;
      if (!rstn) begin
         arready <= 1'b0;
         rvalid  <= 1'b0;
         pend_addr.delete();
         pend_id.delete();
      end else begin
         arready <= ($urandom_range(0, 3) != 0);   // occasional address stall
         if (arvalid && arready) begin
            pend_addr.push_back(araddr);
            pend_id.push_back(arid);
         end
         if (rvalid && rready) begin
            rvalid <= 1'b0;
         end else if (!rvalid && !hold && pend_addr.size() > 0) begin
            pick = $urandom_range(0, pend_addr.size() - 1);   // any pending line
            rid    <= pend_id[pick];
            rdata  <= fill_line(pend_addr[pick]);
            rvalid <= 1'b1;
            pend_addr.delete(pick);
            pend_id.delete(pick);
         end
      end
   end

endmodule

`default_nettype wire

/* design/read_only_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ro_macros.svh"

module read_only_stage import ro_pkg::*; (
   input  wire              clk,
   input  wire              rstn,

   input  wire              req_valid,
   output logic             req_ready,
   input  wire addr_t       req_addr,
   input  wire word_cnt_t   req_n_words,
   input  wire tag_t        req_tag,

   output logic             arvalid,
   input  wire              arready,
   output addr_t            araddr,
   output arid_t            arid,

   input  wire              rvalid,
   output logic             rready,
   input  wire arid_t       rid,
   input  wire line_t       rdata,

   output logic             out_valid,
   input  wire              out_ready,
   output tag_t             out_tag,
   output word_cnt_t        out_word_id,
   output word_t            out_data,
   output logic             out_last,

   output logic             idle        // no thread in use
);

   thread_id_t thread_free;
   thread_id_t thread_ret;
   logic       thread_empty;
   logic       thread_pop;
   logic       thread_push;

   arid_t      arid_free;
   arid_t      arid_ret;
   logic       arid_empty;
   logic       arid_pop;
   logic       arid_push;

   ro_mshr_if mshr_bus ();

   ro_free_list #(
      .entry_t (thread_id_t),
      .DEPTH   (`RO_N_THREADS)
   ) thread_list (
      .clk        (clk),
      .rstn       (rstn),
      .push       (thread_push),
      .push_entry (thread_ret),
      .pop        (thread_pop),
      .entry_out  (thread_free),
      .empty      (thread_empty),
      .all_free   (idle)
   );

   ro_free_list #(
      .entry_t (arid_t),
      .DEPTH   (2 ** `RO_LOG_N_ARID)
   ) arid_list (
      .clk        (clk),
      .rstn       (rstn),
      .push       (arid_push),
      .push_entry (arid_ret),
      .pop        (arid_pop),
      .entry_out  (arid_free),
      .empty      (arid_empty),
      .all_free   ()
   );

   ro_burst_splitter splitter (
      .clk          (clk),
      .rstn         (rstn),
      .req_valid    (req_valid),
      .req_ready    (req_ready),
      .req_addr     (req_addr),
      .req_n_words  (req_n_words),
      .req_tag      (req_tag),
      .thread_free  (thread_free),
      .thread_empty (thread_empty),
      .thread_pop   (thread_pop),
      .arid_free    (arid_free),
      .arid_empty   (arid_empty),
      .arid_pop     (arid_pop),
      .arvalid      (arvalid),
      .arready      (arready),
      .araddr       (araddr),
      .arid         (arid),
      .mshr         (mshr_bus.splitter)
   );

   ro_resp_unpacker unpacker (
      .clk         (clk),
      .rstn        (rstn),
      .rvalid      (rvalid),
      .rready      (rready),
      .rid         (rid),
      .rdata       (rdata),
      .arid_push   (arid_push),
      .arid_ret    (arid_ret),
      .out_valid   (out_valid),
      .out_ready   (out_ready),
      .out_tag     (out_tag),
      .out_word_id (out_word_id),
      .out_data    (out_data),
      .out_last    (out_last),
      .thread_push (thread_push),
      .thread_ret  (thread_ret),
      .mshr        (mshr_bus.unpacker)
   );

endmodule

`default_nettype wire

/* design/ro_resp_unpacker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ro_macros.svh"

module ro_resp_unpacker import ro_pkg::*; (
   input  wire              clk,
   input  wire              rstn,
   input  wire              rvalid,
   output logic             rready,
   input  wire arid_t       rid,
   input  wire line_t       rdata,
   output logic             arid_push,
   output arid_t            arid_ret,
   output logic             out_valid,
   input  wire              out_ready,
   output tag_t             out_tag,
   output word_cnt_t        out_word_id,
   output word_t            out_data,
   output logic             out_last,
   output logic             thread_push,
   output thread_id_t       thread_ret,
   ro_mshr_if.unpacker      mshr
);

   localparam int N_ARID = 2 ** `RO_LOG_N_ARID;

   mshr_entry_t mshr_tab [N_ARID];
   tag_t        ctx_tag  [`RO_N_THREADS];
   word_cnt_t   ctx_left [`RO_N_THREADS];   // words still owed per thread

   logic        cap_valid;
   line_t       cap_data;
   mshr_entry_t cap_entry;
   word_cnt_t   cap_off;

   word_idx_t   lo_idx;
   word_mask_t  next_mask;
   logic        capture;
   logic        out_hs;

   always_ff @(posedge clk) begin
      if (mshr.mshr_wr) begin
         mshr_tab[mshr.mshr_id] <= mshr.mshr_entry;
      end
      if (mshr.ctx_wr) begin
         ctx_tag[mshr.ctx_thread] <= mshr.ctx_tag;
      end
   end

   // lowest pending word of the captured line
   always_comb begin
      lo_idx = '0;
      for (int i = `RO_LINE_WORDS - 1; i >= 0; i--) begin
         if (cap_entry.mask[i]) begin
            lo_idx = word_idx_t'(i);
         end
      end
      next_mask = cap_entry.mask & ~(word_mask_t'(1) << lo_idx);
   end

   assign out_valid   = cap_valid & (|cap_entry.mask);
   assign out_hs      = out_valid & out_ready;
   assign out_data    = cap_data[lo_idx * `RO_WORD_BITS +: `RO_WORD_BITS];
   assign out_tag     = ctx_tag[cap_entry.thread];
   assign out_word_id = cap_entry.start_id + cap_off;
   assign out_last    = out_valid & (ctx_left[cap_entry.thread] == word_cnt_t'(1));

   assign rready    = !cap_valid | (out_hs & (next_mask == '0));
   assign capture   = rvalid & rready;
   assign arid_push = capture;
   assign arid_ret  = rid;

   assign thread_push = out_hs & out_last;
   assign thread_ret  = cap_entry.thread;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         cap_valid <= 1'b0;
      end else if (capture) begin
         cap_valid <= 1'b1;
      end else if (out_hs && next_mask == '0) begin
         cap_valid <= 1'b0;   // line drained
      end
   end

   always_ff @(posedge clk) begin
      if (capture) begin
         cap_data  <= rdata;
         cap_entry <= mshr_tab[rid];
         cap_off   <= '0;
      end else if (out_hs) begin
         cap_entry.mask <= next_mask;
         cap_off        <= cap_off + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int t = 0; t < `RO_N_THREADS; t++) begin
            ctx_left[t] <= '0;
         end
      end else begin
         for (int t = 0; t < `RO_N_THREADS; t++) begin
            if (mshr.ctx_wr && mshr.ctx_thread == thread_id_t'(t)) begin
               ctx_left[t] <= mshr.ctx_n_words;
            end else if (out_hs && cap_entry.thread == thread_id_t'(t)) begin
               ctx_left[t] <= ctx_left[t] - 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* design/ro_burst_splitter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ro_macros.svh"

module ro_burst_splitter import ro_pkg::*; (
   input  wire              clk,
   input  wire              rstn,
   input  wire              req_valid,
   output logic             req_ready,
   input  wire addr_t       req_addr,
   input  wire word_cnt_t   req_n_words,
   input  wire tag_t        req_tag,
   input  wire thread_id_t  thread_free,
   input  wire              thread_empty,
   output logic             thread_pop,
   input  wire arid_t       arid_free,
   input  wire              arid_empty,
   output logic             arid_pop,
   output logic             arvalid,
   input  wire              arready,
   output addr_t            araddr,
   output arid_t            arid,
   ro_mshr_if.splitter      mshr
);

   localparam int    OFF_LSB       = 2;
   localparam int    OFF_MSB       = $clog2(`RO_LINE_WORDS) + 1;
   localparam addr_t LINE_OFF_MASK = addr_t'(`RO_LINE_BITS / 8 - 1);

   logic        busy;         // holds a request with beats left
   addr_t       cur_addr;
   word_cnt_t   cur_left;     // words not yet covered by a beat
   word_cnt_t   cur_start;
   thread_id_t  cur_thread;

   word_idx_t   line_off;
   word_cnt_t   room;
   word_cnt_t   beat_words;
   logic        last_beat;
   logic [31:0] ones;
   logic        accept;
   logic        ar_hs;

   always_comb begin
      line_off   = cur_addr[OFF_MSB:OFF_LSB];
      room       = word_cnt_t'(`RO_LINE_WORDS) - word_cnt_t'(line_off);
      last_beat  = (cur_left <= room);
      beat_words = last_beat ? cur_left : room;
      ones       = (32'd1 << beat_words) - 32'd1;
   end

   assign ar_hs     = arvalid & arready;
   assign req_ready = !thread_empty & (!busy | (ar_hs & last_beat));
   assign accept    = req_valid & req_ready;

   assign thread_pop = accept;
   assign arid_pop   = ar_hs;

   assign arvalid = busy & !arid_empty;   // wait for a free read id
   assign araddr  = cur_addr;
   assign arid    = arid_free;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         busy <= 1'b0;
      end else if (accept) begin
         busy <= 1'b1;
      end else if (ar_hs && last_beat) begin
         busy <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         cur_addr   <= req_addr;
         cur_left   <= req_n_words;
         cur_start  <= '0;
         cur_thread <= thread_free;
      end else if (ar_hs && !last_beat) begin
         cur_addr  <= (cur_addr | LINE_OFF_MASK) + 1'b1;   // next line start
         cur_left  <= cur_left - beat_words;
         cur_start <= cur_start + beat_words;
      end
   end

   assign mshr.mshr_wr             = ar_hs;
   assign mshr.mshr_id             = arid_free;
   assign mshr.mshr_entry.thread   = cur_thread;
   assign mshr.mshr_entry.mask     = word_mask_t'(ones << line_off);
   assign mshr.mshr_entry.start_id = cur_start;

   assign mshr.ctx_wr      = accept;
   assign mshr.ctx_thread  = thread_free;
   assign mshr.ctx_tag     = req_tag;
   assign mshr.ctx_n_words = req_n_words;

endmodule

`default_nettype wire

/* design/ro_free_list.sv */
`timescale 1ns/1ps
`default_nettype none

module ro_free_list #(
   parameter type entry_t = logic [1:0],
   parameter int  DEPTH   = 4
) (
   input  wire          clk,
   input  wire          rstn,
   input  wire          push,
   input  wire entry_t  push_entry,
   input  wire          pop,
   output entry_t       entry_out,
   output logic         empty,
   output logic         all_free
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   entry_t             slots [DEPTH];
   logic [PTR_W-1:0]   head;
   logic [PTR_W-1:0]   tail;
   logic [CNT_W-1:0]   count;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < DEPTH; i++) begin
            slots[i] <= entry_t'(i);   // every id starts out free
         end
         head  <= '0;
         tail  <= '0;
         count <= CNT_W'(DEPTH);
      end else begin
         if (push) begin
            slots[tail] <= push_entry;
            tail        <= ptr_inc(tail);
         end
         if (pop) begin
            head <= ptr_inc(head);
         end
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

   assign entry_out = slots[head];
   assign empty     = (count == '0);
   assign all_free  = (count == CNT_W'(DEPTH));

endmodule

`default_nettype wire

/* design/ro_mshr_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ro_mshr_if import ro_pkg::*; ();

   // written on every read-address handshake
   logic        mshr_wr;
   arid_t       mshr_id;
   mshr_entry_t mshr_entry;

   // written once per accepted request
   logic        ctx_wr;
   thread_id_t  ctx_thread;
   tag_t        ctx_tag;
   word_cnt_t   ctx_n_words;

   modport splitter (
      output mshr_wr, mshr_id, mshr_entry,
      output ctx_wr, ctx_thread, ctx_tag, ctx_n_words
   );

   modport unpacker (
      input  mshr_wr, mshr_id, mshr_entry,
      input  ctx_wr, ctx_thread, ctx_tag, ctx_n_words
   );

endinterface

`default_nettype wire

/* design/ro_pkg.sv */
`default_nettype none

`include "ro_macros.svh"

package ro_pkg;

   typedef logic [31:0]                         addr_t;
   typedef logic [`RO_WORD_BITS-1:0]            word_t;
   typedef logic [`RO_LINE_BITS-1:0]            line_t;
   typedef logic [$clog2(`RO_N_THREADS)-1:0]    thread_id_t;
   typedef logic [`RO_LOG_N_ARID-1:0]           arid_t;
   typedef logic [`RO_TAG_BITS-1:0]             tag_t;
   typedef logic [$clog2(`RO_MAX_WORDS+1)-1:0]  word_cnt_t;   // 0..64
   typedef logic [$clog2(`RO_LINE_WORDS)-1:0]   word_idx_t;
   typedef logic [`RO_LINE_WORDS-1:0]           word_mask_t;

   // one outstanding line read
   typedef struct packed {
      thread_id_t thread;
      word_mask_t mask;      // words of the line that belong to the request
      word_cnt_t  start_id;  // request index of the first masked word
   } mshr_entry_t;

endpackage

`default_nettype wire

/* design/ro_macros.svh */
`ifndef RO_MACROS_SVH
`define RO_MACROS_SVH

// data word width in bits
`define RO_WORD_BITS 32

// words per memory line
`define RO_LINE_WORDS 16

// one full line
`define RO_LINE_BITS 512

// outstanding requests, one thread each
`define RO_N_THREADS 4

// read IDs in flight is 2**RO_LOG_N_ARID
`define RO_LOG_N_ARID 3

`define RO_MAX_WORDS 64
`define RO_TAG_BITS 8

`endif
